// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

	// ==============================
	// Instruction word format
	// ==============================

	// Instruction words are 80 bits wide and postfix payloads reach up to bit 71
	localparam int insWidth = 80;

	// The opcode occupies the low seven bits and everything above is payload
	typedef struct packed {
		logic [insWidth-8:0] payload;
		logic [6:0] opcode;
	} instruction_t;

	// A base instruction in element 0 followed by the three words after it
	typedef instruction_t [3:0] insGroup_t;

	// ==============================
	// Opcodes
	// ==============================

	localparam logic [6:0] NOP = 7'h00;
	localparam logic [6:0] ADDI = 7'h04;
	localparam logic [6:0] CMPI = 7'h05;
	localparam logic [6:0] MULI = 7'h06;
	localparam logic [6:0] DIVI = 7'h07;
	localparam logic [6:0] SUBFI = 7'h08;
	localparam logic [6:0] SLTI = 7'h09;
	localparam logic [6:0] ANDI = 7'h0A;
	localparam logic [6:0] ORI = 7'h0B;
	localparam logic [6:0] EORI = 7'h0C;
	localparam logic [6:0] CSR = 7'h0D;
	localparam logic [6:0] RTD = 7'h0E;
	localparam logic [6:0] JSR = 7'h0F;

	// Loads and the cache control op share the memory immediate format
	localparam logic [6:0] LDB = 7'h10;
	localparam logic [6:0] LDBU = 7'h11;
	localparam logic [6:0] LDW = 7'h12;
	localparam logic [6:0] LDWU = 7'h13;
	localparam logic [6:0] LDT = 7'h14;
	localparam logic [6:0] LDTU = 7'h15;
	localparam logic [6:0] LDO = 7'h16;
	localparam logic [6:0] LDA = 7'h17;
	localparam logic [6:0] CACHE = 7'h18;
	localparam logic [6:0] STB = 7'h20;
	localparam logic [6:0] STW = 7'h21;
	localparam logic [6:0] STT = 7'h22;
	localparam logic [6:0] STO = 7'h23;

	localparam logic [6:0] FENCE = 7'h28;
	localparam logic [6:0] FLT2 = 7'h2A;
	localparam logic [6:0] FLT3 = 7'h2B;
	localparam logic [6:0] VEC = 7'h6C;
	localparam logic [6:0] VECZ = 7'h6D;

	// Each postfix family keeps its upper five bits, the low two give the size
	localparam logic [6:0] PFXA32 = 7'h78;
	localparam logic [6:0] PFXA64 = 7'h79;
	localparam logic [6:0] PFXA128 = 7'h7A;
	localparam logic [6:0] PFXB32 = 7'h74;
	localparam logic [6:0] PFXB64 = 7'h75;
	localparam logic [6:0] PFXB128 = 7'h76;
	localparam logic [6:0] PFXC32 = 7'h70;
	localparam logic [6:0] PFXC64 = 7'h71;
	localparam logic [6:0] PFXC128 = 7'h72;

	// True when op is one of the three sizes of the family led by fam
	function automatic logic isFamily(input logic [6:0] op, input logic [6:0] fam);
		return (op[6:2] == fam[6:2]) && (op[1:0] != 2'd3);
	endfunction

	function automatic logic isPostfix(input logic [6:0] op);
		return isFamily(op, PFXA32) || isFamily(op, PFXB32) || isFamily(op, PFXC32);
	endfunction

	function automatic logic isVecQual(input logic [6:0] op);
		return (op == VEC) || (op == VECZ);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/fpPkg.sv ====
`default_nettype none

package fpPkg;

	// ==============================
	// IEEE 754 binary32
	// ==============================

	localparam int sglExpW = 8;
	localparam int sglManW = 23;
	localparam int sglBias = 127;

	// ==============================
	// IEEE 754 binary64
	// ==============================

	localparam int dblExpW = 11;
	localparam int dblManW = 52;
	localparam int dblBias = 1023;

endpackage

`default_nettype wire

// ==== hdl/instrGroupWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrGroupWindow (
	input wire logic clk,
	input wire logic rst,
	input wire logic insValid,
	input wire isaPkg::instruction_t insWord,
	output logic push,
	output isaPkg::insGroup_t pushGroup
);

	// Slot 0 is the oldest word, slot 3 the newest
	isaPkg::insGroup_t slots;
	isaPkg::insGroup_t nextSlots;
	// Number of valid slots since reset which stops counting at four
	logic [2:0] fill;
	logic groupStart;

	// An accepted word enters at slot 3 and the rest move one place down
	assign nextSlots = {insWord, slots[3:1]};

	// The word about to become oldest must begin an instruction
	assign groupStart = !isaPkg::isPostfix(nextSlots[0].opcode) &&
		!isaPkg::isVecQual(nextSlots[0].opcode);

	// The slots hold still between accepts, so they stay valid through the push cycle
	assign pushGroup = slots;

	always_ff @(posedge clk) begin
		if (rst) begin
			fill <= 3'd0;
			push <= 1'b0;
		end
		else begin
			push <= 1'b0;
			if (insValid) begin
				if (fill != 3'd4) begin
					fill <= fill + 3'd1;
				end
				// Three valid slots now plus the new word make a full window
				push <= (fill >= 3'd3) && groupStart;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (insValid) begin
			slots <= nextSlots;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/groupQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module groupQueue #(
	parameter int queueDepth = 8,
	parameter type itemType = logic [7:0]
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire logic pop,
	input wire itemType pushItem,
	output itemType popItem,
	output logic empty,
	output logic fetchHold
);

	localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntW = $clog2(queueDepth + 1);
	localparam logic [ptrW-1:0] lastPtr = ptrW'(queueDepth - 1);
	localparam logic [cntW-1:0] fullLevel = cntW'(queueDepth);
	// One free entry is kept for the group that may still be in the window
	localparam logic [cntW-1:0] holdLevel = cntW'(queueDepth - 1);

	itemType mem [queueDepth];
	logic [ptrW-1:0] rdPtr;
	logic [ptrW-1:0] wrPtr;
	logic [cntW-1:0] count;
	logic full;
	logic wrEn;
	logic rdEn;

	assign full = count == fullLevel;
	assign empty = count == '0;
	assign fetchHold = count >= holdLevel;
	assign wrEn = push && !full;
	assign rdEn = pop && !empty;

	// The head is visible combinationally so the decoder sees it as soon as it lands
	assign popItem = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (rst) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else begin
			if (wrEn) begin
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
			end
			// Simultaneous push and pop leave the count unchanged
			if (wrEn && !rdEn) begin
				count <= count + 1'b1;
			end
			else if (rdEn && !wrEn) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= pushItem;
		end
	end

	// The window and source must respect fetchHold so the queue never overflows
	noPushWhenFull: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("groupQueue: push while full");

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("groupQueue: pop while empty");

endmodule

`default_nettype wire

// ==== hdl/fpCvt32To64.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpCvt32To64 (
	input wire logic [31:0] sgl,
	output logic [63:0] dbl
);

	localparam int manPad = fpPkg::dblManW - fpPkg::sglManW;
	localparam int expPad = fpPkg::dblExpW - fpPkg::sglExpW;
	// Difference between the two exponent biases
	localparam logic [fpPkg::dblExpW-1:0] rebias =
		fpPkg::dblExpW'(fpPkg::dblBias - fpPkg::sglBias);

	logic sign;
	logic [fpPkg::sglExpW-1:0] sglExp;
	logic [fpPkg::sglManW-1:0] sglMan;
	logic [fpPkg::dblExpW-1:0] dblExp;
	logic [fpPkg::dblManW-1:0] dblMan;

	assign sign = sgl[31];
	assign sglExp = sgl[30:fpPkg::sglManW];
	assign sglMan = sgl[fpPkg::sglManW-1:0];

	// The single mantissa becomes the top of the double mantissa
	assign dblMan = {sglMan, {manPad{1'b0}}};

	always_comb begin
		dblExp = {{expPad{1'b0}}, sglExp} + rebias;
		if (sglExp == '0) begin
			// Denormals are flushed, only the sign survives
			dbl = {sign, {(fpPkg::dblExpW + fpPkg::dblManW){1'b0}}};
		end
		else if (sglExp == '1) begin
			// Infinity stays infinity and a NaN keeps its payload bits
			dbl = {sign, {fpPkg::dblExpW{1'b1}}, dblMan};
		end
		else begin
			dbl = {sign, dblExp, dblMan};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/immDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module immDecoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall,
	input wire logic empty,
	input wire isaPkg::insGroup_t popGroup,
	output logic pop,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic immValid
);

	// Postfix families in the order they are accepted with A first
	localparam logic [2:0][6:0] famOp = {isaPkg::PFXC32, isaPkg::PFXB32, isaPkg::PFXA32};

	isaPkg::instruction_t baseWord;
	isaPkg::instruction_t pfxWord [3];
	logic [2:0] pfxHit;
	logic [2:0] ndx;
	logic [63:0] cvtOut [3];
	logic [63:0] immNext [3];
	logic [63:0] baseImm;
	logic flt;

	// A group is taken whenever one is waiting and downstream is not frozen
	assign pop = !empty && !stall;

	assign baseWord = popGroup[0];
	assign flt = (baseWord.opcode == isaPkg::FLT2) || (baseWord.opcode == isaPkg::FLT3);

	// ==============================
	// Base immediate
	// ==============================

	always_comb begin
		case (baseWord.opcode)
		isaPkg::ADDI, isaPkg::CMPI, isaPkg::MULI, isaPkg::DIVI, isaPkg::SUBFI, isaPkg::SLTI,
		isaPkg::LDB, isaPkg::LDBU, isaPkg::LDW, isaPkg::LDWU, isaPkg::LDT, isaPkg::LDTU,
		isaPkg::LDO, isaPkg::LDA, isaPkg::CACHE,
		isaPkg::STB, isaPkg::STW, isaPkg::STT, isaPkg::STO:
			baseImm = {{51{baseWord[31]}}, baseWord[31:19]};
		// Ones above the field so a short mask keeps the upper bits
		isaPkg::ANDI:
			baseImm = {{51{1'b1}}, baseWord[31:19]};
		isaPkg::ORI, isaPkg::EORI:
			baseImm = {51'd0, baseWord[31:19]};
		isaPkg::CSR:
			baseImm = {53'd0, baseWord[29:19]};
		// Return and call carry a wider 21-bit displacement
		isaPkg::RTD, isaPkg::JSR:
			baseImm = {{43{baseWord[39]}}, baseWord[39:19]};
		isaPkg::FENCE:
			baseImm = {48'd0, baseWord[23:8]};
		default:
			baseImm = '0;
		endcase
	end

	// ==============================
	// Postfix scan
	// ==============================

	always_comb begin
		ndx = 3'd1;
		pfxHit = '0;
		for (int f = 0; f < 3; f++) begin
			pfxWord[f] = '0;
		end
		// A vector qualifier sits between the base and its postfixes
		if (isaPkg::isVecQual(popGroup[1].opcode)) begin
			ndx = 3'd2;
		end
		// Postfixes only count when they come in A, B, C order
		for (int f = 0; f < 3; f++) begin
			if (ndx < 3'd4) begin
				if (isaPkg::isFamily(popGroup[ndx[1:0]].opcode, famOp[f])) begin
					pfxHit[f] = 1'b1;
					pfxWord[f] = popGroup[ndx[1:0]];
					ndx = ndx + 3'd1;
				end
			end
		end
	end

	for (genvar g = 0; g < 3; g++) begin : genCvt
		fpCvt32To64 uCvt (
			.sgl(pfxWord[g][39:8]),
			.dbl(cvtOut[g])
		);
	end

	always_comb begin
		immNext[0] = '0;
		immNext[1] = baseImm;
		immNext[2] = '0;
		for (int f = 0; f < 3; f++) begin
			if (pfxHit[f]) begin
				// The low opcode bits give the postfix size and 128-bit forms decode to zero
				case (pfxWord[f].opcode[1:0])
				2'd0: immNext[f] = flt ? cvtOut[f] : {{32{pfxWord[f][39]}}, pfxWord[f][39:8]};
				2'd1: immNext[f] = pfxWord[f][71:8];
				default: immNext[f] = '0;
				endcase
			end
		end
	end

	// ==============================
	// Output registers
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			immValid <= 1'b0;
		end
		else begin
			immValid <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			imma <= immNext[0];
			immb <= immNext[1];
			immc <= immNext[2];
		end
	end

	// The queue's empty flag must come out of reset clean for immValid to be known
	immValidKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(immValid))
		else $error("immDecoder: immValid unknown");

endmodule

`default_nettype wire

// ==== hdl/immDecodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module immDecodeTop #(
	parameter int queueDepth = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic insValid,
	input wire logic stall,
	input wire isaPkg::instruction_t insWord,
	output logic fetchHold,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic immValid
);

	logic push;
	logic pop;
	logic empty;
	isaPkg::insGroup_t pushGroup;
	isaPkg::insGroup_t popGroup;

	// Words are gathered into groups here
	instrGroupWindow uWindow (
		.clk(clk),
		.rst(rst),
		.insValid(insValid),
		.insWord(insWord),
		.push(push),
		.pushGroup(pushGroup)
	);

	groupQueue #(
		.queueDepth(queueDepth),
		.itemType(isaPkg::insGroup_t)
	) uQueue (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pop(pop),
		.pushItem(pushGroup),
		.popItem(popGroup),
		.empty(empty),
		.fetchHold(fetchHold)
	);

	immDecoder uDecoder (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.empty(empty),
		.popGroup(popGroup),
		.pop(pop),
		.imma(imma),
		.immb(immb),
		.immc(immc),
		.immValid(immValid)
	);

endmodule

`default_nettype wire

// ==== include/immRefModel.svh ====
`ifndef IMM_REF_MODEL_SVH
`define IMM_REF_MODEL_SVH

// Reference single to double widening with denormals flushed to a signed zero
function automatic logic [63:0] refCvt32To64(input logic [31:0] s);
	logic [10:0] e;
	e = {3'd0, s[30:23]} + 11'(fpPkg::dblBias - fpPkg::sglBias);
	if (s[30:23] == 8'd0) begin
		return {s[31], 63'd0};
	end
	if (s[30:23] == 8'hFF) begin
		return {s[31], 11'h7FF, s[22:0], 29'd0};
	end
	return {s[31], e, s[22:0], 29'd0};
endfunction

// Postfix family of an opcode as 0 for A, 1 for B and 2 for C and -1 for any other word
function automatic int refPfxFamily(input logic [6:0] op);
	case (op)
	isaPkg::PFXA32, isaPkg::PFXA64, isaPkg::PFXA128: return 0;
	isaPkg::PFXB32, isaPkg::PFXB64, isaPkg::PFXB128: return 1;
	isaPkg::PFXC32, isaPkg::PFXC64, isaPkg::PFXC128: return 2;
	default: return -1;
	endcase
endfunction

// Vector qualifiers sit between a base word and its postfixes
function automatic logic refIsQual(input logic [6:0] op);
	return (op == isaPkg::VEC) || (op == isaPkg::VECZ);
endfunction

// A word opens a group unless it is a postfix or a vector qualifier
function automatic logic refIsStart(input isaPkg::instruction_t w);
	return (refPfxFamily(w.opcode) < 0) && !refIsQual(w.opcode);
endfunction

// Immediate carried by the base instruction itself
function automatic logic [63:0] refBaseImm(input isaPkg::instruction_t w);
	case (w.opcode)
	isaPkg::ADDI, isaPkg::CMPI, isaPkg::MULI, isaPkg::DIVI, isaPkg::SUBFI, isaPkg::SLTI,
	isaPkg::LDB, isaPkg::LDBU, isaPkg::LDW, isaPkg::LDWU, isaPkg::LDT, isaPkg::LDTU,
	isaPkg::LDO, isaPkg::LDA, isaPkg::CACHE,
	isaPkg::STB, isaPkg::STW, isaPkg::STT, isaPkg::STO:
		return {{51{w[31]}}, w[31:19]};
	isaPkg::ANDI: return {{51{1'b1}}, w[31:19]};
	isaPkg::ORI, isaPkg::EORI: return {51'd0, w[31:19]};
	isaPkg::CSR: return {53'd0, w[29:19]};
	isaPkg::RTD, isaPkg::JSR: return {{43{w[39]}}, w[39:19]};
	isaPkg::FENCE: return {48'd0, w[23:8]};
	default: return 64'd0;
	endcase
endfunction

// Four consecutive sent words starting at base as the window sees them
function automatic isaPkg::insGroup_t refGroupAt(input isaPkg::instruction_t words[$],
		input int base);
	isaPkg::insGroup_t g;
	for (int k = 0; k < 4; k++) begin
		g[k] = words[base + k];
	end
	return g;
endfunction

// Expected imma, immb and immc for one group
function automatic void refDecode(input isaPkg::insGroup_t g, output logic [63:0] a,
		output logic [63:0] b, output logic [63:0] c);
	logic [63:0] r [3];
	logic flt;
	int n;
	r[0] = 64'd0;
	r[1] = refBaseImm(g[0]);
	r[2] = 64'd0;
	flt = (g[0].opcode == isaPkg::FLT2) || (g[0].opcode == isaPkg::FLT3);
	n = refIsQual(g[1].opcode) ? 2 : 1;
	for (int f = 0; f < 3; f++) begin
		if (n < 4) begin
			if (refPfxFamily(g[n].opcode) == f) begin
				case (g[n].opcode)
				isaPkg::PFXA32, isaPkg::PFXB32, isaPkg::PFXC32:
					r[f] = flt ? refCvt32To64(g[n][39:8]) : {{32{g[n][39]}}, g[n][39:8]};
				isaPkg::PFXA64, isaPkg::PFXB64, isaPkg::PFXC64:
					r[f] = g[n][71:8];
				default:
					r[f] = 64'd0;
				endcase
				n++;
			end
		end
	end
	a = r[0];
	b = r[1];
	c = r[2];
endfunction

`endif

// ==== tb/immDecodeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "immRefModel.svh"

module immDecodeTb;

	localparam int queueDepth = 8;
	localparam int seqCount = 150;
	// Wait limits in clock cycles
	localparam int holdLimit = 200;
	localparam int drainLimit = 2000;

	// Base opcodes drawn by the stimulus
	// The float ops appear twice so widening is hit often
	localparam logic [6:0] baseOps [32] = '{
		isaPkg::NOP, isaPkg::ADDI, isaPkg::CMPI, isaPkg::MULI, isaPkg::DIVI, isaPkg::SUBFI,
		isaPkg::SLTI, isaPkg::ANDI, isaPkg::ORI, isaPkg::EORI, isaPkg::CSR, isaPkg::RTD,
		isaPkg::JSR, isaPkg::LDB, isaPkg::LDBU, isaPkg::LDW, isaPkg::LDWU, isaPkg::LDT,
		isaPkg::LDTU, isaPkg::LDO, isaPkg::LDA, isaPkg::CACHE, isaPkg::STB, isaPkg::STW,
		isaPkg::STT, isaPkg::STO, isaPkg::FENCE, isaPkg::FLT2, isaPkg::FLT3, isaPkg::FLT2,
		isaPkg::FLT3, isaPkg::ANDI
	};

	logic clk;
	logic rst;
	logic insValid;
	logic stall;
	isaPkg::instruction_t insWord;
	logic fetchHold;
	logic [63:0] imma;
	logic [63:0] immb;
	logic [63:0] immc;
	logic immValid;

	logic [63:0] rngState;
	// When set, every cycle draws a new stall level
	bit randStall;
	// Groups completed while this is set must come out exactly 3 cycles later
	bit latChk;
	bit prevStall;
	int cyc = 0;
	int valueErrors = 0;
	int timingErrors = 0;
	int countErrors = 0;
	int results = 0;

	// Every accepted word in order so the model can replay the window over it
	isaPkg::instruction_t sent [$];
	logic [63:0] expA [$];
	logic [63:0] expB [$];
	logic [63:0] expC [$];
	int expCyc [$];
	bit expLat [$];

	immDecodeTop #(
		.queueDepth(queueDepth)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.insValid(insValid),
		.stall(stall),
		.insWord(insWord),
		.fetchHold(fetchHold),
		.imma(imma),
		.immb(immb),
		.immc(immc),
		.immValid(immValid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// 64-bit xorshift
	function automatic logic [63:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 7);
		rngState = rngState ^ (rngState << 17);
		return rngState;
	endfunction

	function automatic isaPkg::instruction_t randWord(input logic [6:0] op);
		isaPkg::instruction_t w;
		logic [63:0] hi;
		logic [63:0] lo;
		hi = nextRand();
		lo = nextRand();
		w = {hi[15:0], lo};
		w.opcode = op;
		return w;
	endfunction

	// Single precision value of a random class with normals the most common
	function automatic logic [31:0] fltValue(input logic [63:0] r);
		logic [31:0] v;
		v = r[31:0];
		case (r[34:32])
		3'd0: v = {r[31], 31'd0};
		3'd1: v = {r[31], 8'd0, r[22:1], 1'b1};
		3'd2: v = {r[31], 8'hFF, 23'd0};
		// A quiet or signalling NaN keeps a nonzero mantissa
		3'd3: v = {r[31], 8'hFF, r[22:1], 1'b1};
		default: begin
			if (v[30:23] == 8'd0 || v[30:23] == 8'hFF) begin
				v[30:23] = 8'h7F;
			end
		end
		endcase
		return v;
	endfunction

	task automatic timeoutAbort(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic stepCycle();
		logic [63:0] r;
		@(posedge clk);
		#2;
		if (randStall) begin
			r = nextRand();
			stall = (r[1:0] == 2'd0);
		end
	endtask

	task automatic sendWord(input isaPkg::instruction_t w);
		int n;
		n = 0;
		while (fetchHold && n < holdLimit) begin
			stepCycle();
			n++;
		end
		if (fetchHold) begin
			timeoutAbort("fetchHold to fall before sending a word");
		end
		else begin
			insValid = 1'b1;
			insWord = w;
			stepCycle();
			insValid = 1'b0;
		end
	endtask

	// A base word, maybe a vector qualifier, then A, B and C postfixes each present at random
	task automatic sendSequence();
		logic [63:0] r;
		logic [6:0] fam [3];
		logic [1:0] sz;
		isaPkg::instruction_t w;
		bit flt;
		fam[0] = isaPkg::PFXA32;
		fam[1] = isaPkg::PFXB32;
		fam[2] = isaPkg::PFXC32;
		r = nextRand();
		flt = (baseOps[r[4:0]] == isaPkg::FLT2) || (baseOps[r[4:0]] == isaPkg::FLT3);
		sendWord(randWord(baseOps[r[4:0]]));
		if (r[7:6] == 2'd0) begin
			sendWord(randWord(r[8] ? isaPkg::VECZ : isaPkg::VEC));
		end
		for (int f = 0; f < 3; f++) begin
			r = nextRand();
			if (r[0]) begin
				// Size code 3 is not a postfix, fold it onto the 32-bit form
				sz = (r[2:1] == 2'd3) ? 2'd0 : r[2:1];
				w = randWord({fam[f][6:2], sz});
				if (flt && sz == 2'd0) begin
					w[39:8] = fltValue(nextRand());
				end
				sendWord(w);
			end
		end
	endtask

	task automatic waitDrain(input string what);
		int n;
		n = 0;
		while (expA.size() != 0 && n < drainLimit) begin
			stepCycle();
			n++;
		end
		if (expA.size() != 0) begin
			timeoutAbort(what);
		end
		else begin
			// A few quiet cycles catch any stray immValid
			repeat (4) stepCycle();
		end
	endtask

	// ==============================
	// Model and checks
	// ==============================

	task automatic recordWord(input isaPkg::instruction_t w);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		int base;
		sent.push_back(w);
		base = sent.size() - 4;
		// The word three places back now has all three successors
		if (base >= 0) begin
			if (refIsStart(sent[base])) begin
				refDecode(refGroupAt(sent, base), a, b, c);
				expA.push_back(a);
				expB.push_back(b);
				expC.push_back(c);
				expCyc.push_back(cyc);
				expLat.push_back(latChk);
			end
		end
	endtask

	task automatic checkResult();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		int acc;
		bit lat;
		results++;
		if (prevStall) begin
			countErrors++;
			$display("immValid at %0t came from a cycle where stall was high", $time);
		end
		if (expA.size() == 0) begin
			countErrors++;
			$display("immValid at %0t with no result left in the model", $time);
		end
		else begin
			a = expA.pop_front();
			b = expB.pop_front();
			c = expC.pop_front();
			acc = expCyc.pop_front();
			lat = expLat.pop_front();
			if (imma !== a || immb !== b || immc !== c) begin
				valueErrors++;
				$display("[FAIL] %0t result %0d got %h %h %h expected %h %h %h",
					$time, results, imma, immb, immc, a, b, c);
			end
			if (lat && (cyc - acc) != 3) begin
				timingErrors++;
				$display("[FAIL] %0t result %0d came %0d cycles after its last word, expected 3",
					$time, results, cyc - acc);
			end
		end
	endtask

	// Sampled on the rising edge, before the DUT registers update
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!rst) begin
			if (insValid) begin
				recordWord(insWord);
			end
			if (immValid) begin
				checkResult();
			end
		end
		prevStall = stall;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int n;
		logic [63:0] r;
		rst = 1'b1;
		insValid = 1'b0;
		stall = 1'b0;
		insWord = '0;
		rngState = 64'd65197;
		randStall = 1'b0;
		latChk = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		if (immValid !== 1'b0 || fetchHold !== 1'b0) begin
			countErrors++;
			$display("[FAIL] %0t after reset immValid=%b fetchHold=%b, expected both low",
				$time, immValid, fetchHold);
		end

		// Unstalled traffic with exact latency
		latChk = 1'b1;
		repeat (seqCount) sendSequence();
		latChk = 1'b0;
		waitDrain("results of the unstalled phase");

		// Random stalls
		randStall = 1'b1;
		repeat (seqCount) sendSequence();
		randStall = 1'b0;
		stall = 1'b0;
		waitDrain("results of the random stall phase");

		// Hold stall until the queue asks the source to stop
		stall = 1'b1;
		n = 0;
		while (!fetchHold && n < 64) begin
			r = nextRand();
			sendWord(randWord(baseOps[r[4:0]]));
			n++;
		end
		if (!fetchHold) begin
			countErrors++;
			$display("fetchHold never rose while stall was held");
		end
		repeat (8) stepCycle();
		stall = 1'b0;

		// Three NOPs give the last base words their successors
		repeat (3) sendWord(randWord(isaPkg::NOP));
		waitDrain("results after the long stall");

		$display("Checked %0d results: %0d value errors, %0d timing errors, %0d count errors",
			results, valueErrors, timingErrors, countErrors);
		if (valueErrors == 0 && timingErrors == 0 && countErrors == 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hdl/isaPkg.sv
hdl/fpPkg.sv
hdl/instrGroupWindow.sv
hdl/groupQueue.sv
hdl/fpCvt32To64.sv
hdl/immDecoder.sv
hdl/immDecodeTop.sv
tb/immDecodeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= immDecodeTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
